/* cache_top.f */
design/cache_geom_pkg.sv
design/mem_bus_pkg.sv
design/cache_array_if.sv
design/cache_array.sv
design/cache_lookup.sv
design/refill_buffer.sv
design/cache_ctrl.sv
design/cache_top.sv
sim/mem_model.sv
sim/tb_cache_top.sv

/* design/cache_array.sv */
`timescale 1ns/10ps

module cache_array (
  input logic         clk,
  input logic         resetn,
  cache_array_if.array arr
);

  localparam int BYTES = $bits(mem_bus_pkg::wstrb_t);
  localparam int WORD_W = $bits(mem_bus_pkg::word_t);

  cache_geom_pkg::tag_t   tag_mem  [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::NUM_SETS];
  mem_bus_pkg::line_t     line_mem [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::NUM_SETS];
  logic [cache_geom_pkg::NUM_SETS-1:0] valid_q [cache_geom_pkg::NUM_WAYS];
  logic [cache_geom_pkg::NUM_SETS-1:0] dirty_q [cache_geom_pkg::NUM_WAYS];

  // valid and dirty bits per set
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
    end else if (arr.wr_en) begin
      if (arr.wr_word_only) begin
        dirty_q[arr.wr_way][arr.wr_index] <= 1'b1;   // store hit dirties the line
      end else begin
        valid_q[arr.wr_way][arr.wr_index] <= 1'b1;
        dirty_q[arr.wr_way][arr.wr_index] <= arr.wr_dirty;
      end
    end
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    if (arr.wr_en) begin
      if (arr.wr_word_only) begin
        for (int b = 0; b < BYTES; b++) begin
          if (arr.wr_wstrb[b]) begin
            line_mem[arr.wr_way][arr.wr_index][arr.wr_word_sel*WORD_W + b*8 +: 8]
              <= arr.wr_word[b*8 +: 8];
          end
        end
      end else begin
        tag_mem[arr.wr_way][arr.wr_index]  <= arr.wr_tag;
        line_mem[arr.wr_way][arr.wr_index] <= arr.wr_line;
      end
    end
  end

  // read all ways, data one cycle later, held while rd_en is low
  always_ff @(posedge clk) begin
    if (arr.rd_en) begin
      for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
        arr.rd_tag[w]   <= tag_mem[w][arr.rd_index];
        arr.rd_valid[w] <= valid_q[w][arr.rd_index];
        arr.rd_dirty[w] <= dirty_q[w][arr.rd_index];
        arr.rd_line[w]  <= line_mem[w][arr.rd_index];
      end
    end
  end

endmodule

/* design/cache_array_if.sv */
`timescale 1ns/10ps

interface cache_array_if;

  // read side
  logic                       rd_en;
  cache_geom_pkg::index_t     rd_index;

  // write side
  logic                       wr_en;
  logic                       wr_word_only;   // strobed word instead of full line
  cache_geom_pkg::way_t       wr_way;
  cache_geom_pkg::index_t     wr_index;
  cache_geom_pkg::word_sel_t  wr_word_sel;
  mem_bus_pkg::wstrb_t        wr_wstrb;
  mem_bus_pkg::word_t         wr_word;
  cache_geom_pkg::tag_t       wr_tag;
  logic                       wr_dirty;
  mem_bus_pkg::line_t         wr_line;

  // registered read data, all ways at one index
  cache_geom_pkg::tag_t                    rd_tag  [cache_geom_pkg::NUM_WAYS];
  logic [cache_geom_pkg::NUM_WAYS-1:0]     rd_valid;
  logic [cache_geom_pkg::NUM_WAYS-1:0]     rd_dirty;
  mem_bus_pkg::line_t                      rd_line [cache_geom_pkg::NUM_WAYS];

  modport ctrl (
    output rd_en, rd_index,
    output wr_en, wr_word_only, wr_way, wr_index, wr_word_sel, wr_wstrb, wr_word,
    output wr_tag, wr_dirty, wr_line,
    input  rd_tag, rd_valid, rd_dirty, rd_line
  );

  modport array (
    input  rd_en, rd_index,
    input  wr_en, wr_word_only, wr_way, wr_index, wr_word_sel, wr_wstrb, wr_word,
    input  wr_tag, wr_dirty, wr_line,
    output rd_tag, rd_valid, rd_dirty, rd_line
  );

  modport lookup (
    input  rd_tag, rd_valid, rd_line
  );

endinterface

/* design/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl (
  input  logic                       clk,
  input  logic                       resetn,
  // cpu side
  input  logic                       valid_i,
  input  logic                       op_i,        // 1 = store
  input  mem_bus_pkg::addr_t         addr_i,
  input  mem_bus_pkg::wstrb_t        wstrb_i,
  input  mem_bus_pkg::word_t         wdata_i,
  output logic                       addr_ok_o,
  output logic                       data_ok_o,
  // memory read
  output logic                       rd_req_o,
  output mem_bus_pkg::addr_t         rd_addr_o,
  input  logic                       rd_rdy_i,
  input  logic                       ret_valid_i,
  input  logic                       ret_last_i,
  // memory write
  output logic                       wr_req_o,
  output mem_bus_pkg::addr_t         wr_addr_o,
  output mem_bus_pkg::line_t         wr_data_o,
  input  logic                       wr_rdy_i,
  // array and helpers
  cache_array_if.ctrl                arr,
  input  logic                       hit_i,
  input  cache_geom_pkg::way_t       hit_way_i,
  input  cache_geom_pkg::word_sel_t  beat_idx_i,
  input  mem_bus_pkg::line_t         refill_line_i,
  output logic                       beat_en_o,
  output logic                       refill_clear_o,
  output logic                       refill_phase_o,
  output cache_geom_pkg::word_sel_t  req_word_sel_o,
  output cache_geom_pkg::tag_t       req_tag_o,
  output mem_bus_pkg::wstrb_t        pend_wstrb_o,
  output mem_bus_pkg::word_t         pend_wdata_o,
  output logic                       pend_store_o
);

  cache_geom_pkg::cache_state_e state_q, state_d;

  // request buffer
  mem_bus_pkg::addr_t   req_addr_q;
  logic                 req_op_q;
  mem_bus_pkg::word_t   req_wdata_q;
  mem_bus_pkg::wstrb_t  req_wstrb_q;

  cache_geom_pkg::tag_t     req_tag;
  cache_geom_pkg::index_t   req_index;
  cache_geom_pkg::offset_t  req_offset;

  logic                  victim_toggle_q;
  cache_geom_pkg::way_t  victim_way_q;
  logic                  fill_q;          // refilled line waits for BLOCK
  logic                  load_hit;
  logic                  accept;
  logic                  victim_dirty;

  assign {req_tag, req_index, req_offset} = req_addr_q;

  assign load_hit  = (state_q == cache_geom_pkg::LOOKUP) && hit_i && !req_op_q;
  assign accept    = valid_i && (state_q == cache_geom_pkg::IDLE || load_hit);
  assign addr_ok_o = accept;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr_q  <= addr_i;
      req_op_q    <= op_i;
      req_wdata_q <= wdata_i;
      req_wstrb_q <= wstrb_i;
    end
  end

  // free-running victim pick, latched on a miss
  always_ff @(posedge clk) begin
    if (!resetn) begin
      victim_toggle_q <= 1'b0;
      victim_way_q    <= '0;
    end else begin
      victim_toggle_q <= ~victim_toggle_q;
      if (state_q == cache_geom_pkg::LOOKUP && !hit_i) begin
        victim_way_q <= cache_geom_pkg::way_t'(victim_toggle_q);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      fill_q <= 1'b0;
    end else if (state_q == cache_geom_pkg::REFILL && ret_valid_i && ret_last_i) begin
      fill_q <= 1'b1;
    end else if (state_q == cache_geom_pkg::BLOCK) begin
      fill_q <= 1'b0;
    end
  end

  always_comb begin
    state_d   = state_q;
    data_ok_o = 1'b0;
    unique case (state_q)
      cache_geom_pkg::IDLE: begin
        if (accept) state_d = cache_geom_pkg::LOOKUP;
      end
      cache_geom_pkg::LOOKUP: begin
        data_ok_o = hit_i;
        if (!hit_i) begin
          state_d = cache_geom_pkg::MISS;
        end else if (req_op_q) begin
          state_d = cache_geom_pkg::WRITE;
        end else begin
          state_d = accept ? cache_geom_pkg::LOOKUP : cache_geom_pkg::IDLE;
        end
      end
      cache_geom_pkg::WRITE:     state_d = cache_geom_pkg::BLOCK;
      cache_geom_pkg::MISS: begin
        if (wr_rdy_i) state_d = cache_geom_pkg::WRITEBACK;
      end
      cache_geom_pkg::WRITEBACK: state_d = cache_geom_pkg::REPLACE;
      cache_geom_pkg::REPLACE: begin
        if (rd_rdy_i) state_d = cache_geom_pkg::REFILL;
      end
      cache_geom_pkg::REFILL: begin
        if (ret_valid_i) begin
          // load returns on its own word, store on the last beat
          data_ok_o = req_op_q ? ret_last_i : (beat_idx_i == req_word_sel_o);
          if (ret_last_i) state_d = cache_geom_pkg::BLOCK;
        end
      end
      cache_geom_pkg::BLOCK:     state_d = cache_geom_pkg::IDLE;
      default:                   state_d = cache_geom_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= cache_geom_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // array read: new request, or victim reread in MISS
  assign arr.rd_en    = accept || (state_q == cache_geom_pkg::MISS);
  assign arr.rd_index = accept ? addr_i[cache_geom_pkg::OFFSET_W +: cache_geom_pkg::INDEX_W]
                               : req_index;

  // word write on store hit, line write after refill
  // array outputs still hold the lookup result during WRITE
  assign arr.wr_en        = (state_q == cache_geom_pkg::WRITE) ||
                            (state_q == cache_geom_pkg::BLOCK && fill_q);
  assign arr.wr_word_only = (state_q == cache_geom_pkg::WRITE);
  assign arr.wr_way       = (state_q == cache_geom_pkg::WRITE) ? hit_way_i : victim_way_q;
  assign arr.wr_index     = req_index;
  assign arr.wr_word_sel  = req_word_sel_o;
  assign arr.wr_wstrb     = req_wstrb_q;
  assign arr.wr_word      = req_wdata_q;
  assign arr.wr_tag       = req_tag;
  assign arr.wr_dirty     = req_op_q;   // store miss line is already merged
  assign arr.wr_line      = refill_line_i;

  // victim writeback
  assign victim_dirty = arr.rd_valid[victim_way_q] && arr.rd_dirty[victim_way_q];
  assign wr_req_o     = (state_q == cache_geom_pkg::WRITEBACK) && victim_dirty;
  assign wr_addr_o    = {arr.rd_tag[victim_way_q], req_index, cache_geom_pkg::offset_t'(0)};
  assign wr_data_o    = arr.rd_line[victim_way_q];

  // line read from offset zero
  assign rd_req_o  = (state_q == cache_geom_pkg::REPLACE);
  assign rd_addr_o = {req_tag, req_index, cache_geom_pkg::offset_t'(0)};

  assign beat_en_o      = (state_q == cache_geom_pkg::REFILL) && ret_valid_i;
  assign refill_clear_o = (state_q == cache_geom_pkg::REPLACE);
  assign refill_phase_o = (state_q == cache_geom_pkg::REFILL);

  assign req_word_sel_o = req_offset[cache_geom_pkg::OFFSET_W-1 -: cache_geom_pkg::WORD_SEL_W];
  assign req_tag_o      = req_tag;
  assign pend_wstrb_o   = req_wstrb_q;
  assign pend_wdata_o   = req_wdata_q;
  assign pend_store_o   = req_op_q;

endmodule

/* design/cache_geom_pkg.sv */
package cache_geom_pkg;

  // two ways of 4 KB, 16-byte lines
  localparam int NUM_WAYS   = 2;
  localparam int NUM_SETS   = 256;

  // address split: tag | index | offset
  localparam int OFFSET_W   = 4;
  localparam int INDEX_W    = 8;
  localparam int TAG_W      = 20;
  localparam int WORD_SEL_W = 2;   // word number inside a line

  typedef logic [TAG_W-1:0]              tag_t;
  typedef logic [INDEX_W-1:0]            index_t;
  typedef logic [OFFSET_W-1:0]           offset_t;
  typedef logic [WORD_SEL_W-1:0]         word_sel_t;
  typedef logic [$clog2(NUM_WAYS)-1:0]   way_t;

  // main controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITE,      // store hit goes into the array
    MISS,       // wait for write channel, read victim
    WRITEBACK,  // victim out if dirty
    REPLACE,    // line read request
    REFILL,     // beats coming back
    BLOCK       // one quiet cycle before idle
  } cache_state_e;

endpackage

/* design/cache_lookup.sv */
`timescale 1ns/10ps

module cache_lookup (
  cache_array_if.lookup              arr,
  input  cache_geom_pkg::tag_t       req_tag_i,
  input  cache_geom_pkg::word_sel_t  req_word_sel_i,
  output logic                       hit_o,
  output cache_geom_pkg::way_t       hit_way_o,
  output mem_bus_pkg::word_t         hit_word_o
);

  localparam int WORD_W = $bits(mem_bus_pkg::word_t);

  logic [cache_geom_pkg::NUM_WAYS-1:0] way_hit;
  mem_bus_pkg::line_t                  hit_line;

  // tag compare on valid ways
  always_comb begin
    for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
      way_hit[w] = arr.rd_valid[w] && (arr.rd_tag[w] == req_tag_i);
    end
  end

  assign hit_o = |way_hit;

  // at most one way matches
  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_way_o = cache_geom_pkg::way_t'(w);
      end
    end
  end

  assign hit_line   = arr.rd_line[hit_way_o];
  assign hit_word_o = hit_line[req_word_sel_i*WORD_W +: WORD_W];   // requested word

endmodule

/* design/cache_top.sv */
`timescale 1ns/10ps

module cache_top (
  input  logic                clk,
  input  logic                resetn,
  // cpu side
  input  logic                valid_i,
  input  logic                op_i,
  input  mem_bus_pkg::addr_t  addr_i,
  input  mem_bus_pkg::wstrb_t wstrb_i,
  input  mem_bus_pkg::word_t  wdata_i,
  output logic                addr_ok_o,
  output logic                data_ok_o,
  output mem_bus_pkg::word_t  rdata_o,
  // memory read
  output logic                rd_req_o,
  output mem_bus_pkg::addr_t  rd_addr_o,
  input  logic                rd_rdy_i,
  input  logic                ret_valid_i,
  input  logic                ret_last_i,
  input  mem_bus_pkg::word_t  ret_data_i,
  // memory write
  output logic                wr_req_o,
  output mem_bus_pkg::addr_t  wr_addr_o,
  output mem_bus_pkg::line_t  wr_data_o,
  input  logic                wr_rdy_i
);

  logic                       hit;
  cache_geom_pkg::way_t       hit_way;
  mem_bus_pkg::word_t         hit_word;
  cache_geom_pkg::word_sel_t  beat_idx;
  mem_bus_pkg::line_t         refill_line;
  logic                       beat_en;
  logic                       refill_clear;
  logic                       refill_phase;
  cache_geom_pkg::word_sel_t  req_word_sel;
  cache_geom_pkg::tag_t       req_tag;
  mem_bus_pkg::wstrb_t        pend_wstrb;
  mem_bus_pkg::word_t         pend_wdata;
  logic                       pend_store;

  cache_array_if u_arr_if ();

  cache_ctrl u_ctrl (
    .clk            (clk),
    .resetn         (resetn),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .addr_i         (addr_i),
    .wstrb_i        (wstrb_i),
    .wdata_i        (wdata_i),
    .addr_ok_o      (addr_ok_o),
    .data_ok_o      (data_ok_o),
    .rd_req_o       (rd_req_o),
    .rd_addr_o      (rd_addr_o),
    .rd_rdy_i       (rd_rdy_i),
    .ret_valid_i    (ret_valid_i),
    .ret_last_i     (ret_last_i),
    .wr_req_o       (wr_req_o),
    .wr_addr_o      (wr_addr_o),
    .wr_data_o      (wr_data_o),
    .wr_rdy_i       (wr_rdy_i),
    .arr            (u_arr_if.ctrl),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .beat_idx_i     (beat_idx),
    .refill_line_i  (refill_line),
    .beat_en_o      (beat_en),
    .refill_clear_o (refill_clear),
    .refill_phase_o (refill_phase),
    .req_word_sel_o (req_word_sel),
    .req_tag_o      (req_tag),
    .pend_wstrb_o   (pend_wstrb),
    .pend_wdata_o   (pend_wdata),
    .pend_store_o   (pend_store)
  );

  cache_array u_array (
    .clk    (clk),
    .resetn (resetn),
    .arr    (u_arr_if.array)
  );

  cache_lookup u_lookup (
    .arr            (u_arr_if.lookup),
    .req_tag_i      (req_tag),
    .req_word_sel_i (req_word_sel),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .hit_word_o     (hit_word)
  );

  refill_buffer u_refill (
    .clk             (clk),
    .resetn          (resetn),
    .beat_en_i       (beat_en),
    .clear_i         (refill_clear),
    .ret_data_i      (ret_data_i),
    .pend_store_i    (pend_store),
    .pend_word_sel_i (req_word_sel),
    .pend_wstrb_i    (pend_wstrb),
    .pend_wdata_i    (pend_wdata),
    .beat_idx_o      (beat_idx),
    .line_o          (refill_line)
  );

  // load miss returns straight from the bus
  assign rdata_o = refill_phase ? ret_data_i : hit_word;

endmodule

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int BEATS_PER_LINE = 4;
  localparam int LINE_W         = WORD_W * BEATS_PER_LINE;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [WORD_W/8-1:0] wstrb_t;   // one bit per byte

  // word 0 sits in the low bits
  typedef logic [LINE_W-1:0]   line_t;

endpackage

/* design/refill_buffer.sv */
`timescale 1ns/10ps

module refill_buffer (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       beat_en_i,
  input  logic                       clear_i,
  input  mem_bus_pkg::word_t         ret_data_i,
  input  logic                       pend_store_i,
  input  cache_geom_pkg::word_sel_t  pend_word_sel_i,
  input  mem_bus_pkg::wstrb_t        pend_wstrb_i,
  input  mem_bus_pkg::word_t         pend_wdata_i,
  output cache_geom_pkg::word_sel_t  beat_idx_o,
  output mem_bus_pkg::line_t         line_o
);

  localparam int WORD_W = $bits(mem_bus_pkg::word_t);

  cache_geom_pkg::word_sel_t beat_idx_q;
  mem_bus_pkg::word_t        beat_word;
  mem_bus_pkg::line_t        line_q;

  // store bytes override the returning word
  always_comb begin
    beat_word = ret_data_i;
    if (pend_store_i && beat_idx_q == pend_word_sel_i) begin
      for (int b = 0; b < $bits(mem_bus_pkg::wstrb_t); b++) begin
        if (pend_wstrb_i[b]) begin
          beat_word[b*8 +: 8] = pend_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || clear_i) begin
      beat_idx_q <= '0;
    end else if (beat_en_i) begin
      beat_idx_q <= beat_idx_q + 1'b1;   // wraps after the last beat
    end
  end

  always_ff @(posedge clk) begin
    if (beat_en_i) begin
      for (int i = 0; i < mem_bus_pkg::BEATS_PER_LINE; i++) begin
        if (beat_idx_q == i) begin
          line_q[i*WORD_W +: WORD_W] <= beat_word;
        end
      end
    end
  end

  assign beat_idx_o = beat_idx_q;
  assign line_o     = line_q;

endmodule

/* sim/mem_model.sv */
`timescale 1ns/10ps

module mem_model (
  input  logic                clk,
  input  logic                resetn,
  // read burst
  input  logic                rd_req_i,
  input  mem_bus_pkg::addr_t  rd_addr_i,
  output logic                rd_rdy_o,
  output logic                ret_valid_o,
  output logic                ret_last_o,
  output mem_bus_pkg::word_t  ret_data_o,
  // write burst
  input  logic                wr_req_i,
  input  mem_bus_pkg::addr_t  wr_addr_i,
  input  mem_bus_pkg::line_t  wr_data_i,
  output logic                wr_rdy_o
);

  integer seed = 71;
  mem_bus_pkg::word_t mem [mem_bus_pkg::addr_t];   // sparse word storage

  // untouched words depend on every address bit
  function automatic mem_bus_pkg::word_t fill_word(input mem_bus_pkg::addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic mem_bus_pkg::word_t read_word(input mem_bus_pkg::addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_word(a);
  endfunction

  function automatic int draw_gap();
    return $unsigned($random(seed)) % 4;
  endfunction

  initial begin : read_side
    int n;
    mem_bus_pkg::addr_t base;
    rd_rdy_o    = 1'b0;
    ret_valid_o = 1'b0;
    ret_last_o  = 1'b0;
    ret_data_o  = '0;
    forever begin
      @(posedge clk);
      #1;
      ret_valid_o = 1'b0;
      ret_last_o  = 1'b0;
      if (resetn && rd_req_i) begin
        n = draw_gap();
        repeat (n) begin
          @(posedge clk);
          #1;
        end
        rd_rdy_o = 1'b1;   // address taken here
        base     = {rd_addr_i[31:4], 4'h0};
        for (int b = 0; b < mem_bus_pkg::BEATS_PER_LINE; b++) begin
          @(posedge clk);
          #1;
          rd_rdy_o    = 1'b0;
          ret_valid_o = 1'b0;
          n = draw_gap();
          repeat (n) begin
            @(posedge clk);
            #1;
          end
          ret_valid_o = 1'b1;
          ret_last_o  = (b == mem_bus_pkg::BEATS_PER_LINE - 1);
          ret_data_o  = read_word(base + 4 * b);
        end
      end
    end
  end

  // draws after the read side within each cycle
  initial begin : write_side
    wr_rdy_o = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      wr_rdy_o = resetn && (draw_gap() != 0);   // low about one cycle in four
    end
  end

  // whole line lands while wr_req_i is high
  always @(negedge clk) begin : write_capture
    mem_bus_pkg::addr_t base;
    if (resetn && wr_req_i) begin
      base = {wr_addr_i[31:4], 4'h0};
      for (int w = 0; w < mem_bus_pkg::BEATS_PER_LINE; w++) begin
        mem[base + 4 * w] = wr_data_i[w*32 +: 32];
      end
    end
  end

endmodule

/* sim/tb_cache_top.sv */
`timescale 1ns/10ps

module tb_cache_top;

  localparam int WAIT_LIMIT = 300;   // cycles

  typedef struct packed {
    logic                 op;    // 1 = store
    mem_bus_pkg::addr_t   addr;
    mem_bus_pkg::wstrb_t  wstrb;
    mem_bus_pkg::word_t   wdata;
    logic                 hit;   // must hit with one cycle latency
  } row_t;

  logic                clk = 1'b0;
  logic                resetn;
  logic                valid_i;
  logic                op_i;
  mem_bus_pkg::addr_t  addr_i;
  mem_bus_pkg::wstrb_t wstrb_i;
  mem_bus_pkg::word_t  wdata_i;
  logic                addr_ok_o;
  logic                data_ok_o;
  mem_bus_pkg::word_t  rdata_o;
  logic                rd_req_o;
  logic                rd_rdy_i;
  logic                ret_valid_i;
  logic                ret_last_i;
  mem_bus_pkg::addr_t  rd_addr_o;
  mem_bus_pkg::word_t  ret_data_i;
  logic                wr_req_o;
  logic                wr_rdy_i;
  mem_bus_pkg::addr_t  wr_addr_o;
  mem_bus_pkg::line_t  wr_data_o;

  row_t               table_q [$];
  mem_bus_pkg::word_t ref_mem [mem_bus_pkg::addr_t];
  logic               dirty_lines [mem_bus_pkg::addr_t];   // stored lines not yet written back

  // accepted requests in order
  mem_bus_pkg::addr_t pend_addr_q [$];
  mem_bus_pkg::word_t pend_data_q [$];
  logic               pend_load_q [$];
  logic               pend_hit_q  [$];
  int                 pend_cyc_q  [$];

  int   cyc = 0;
  int   mismatch_cnt = 0;
  int   timeout_cnt = 0;
  int   other_cnt = 0;
  int   wb_cnt = 0;
  logic timed_out = 1'b0;

  always #4 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  cache_top u_dut (
    .clk(clk), .resetn(resetn),
    .valid_i(valid_i), .op_i(op_i), .addr_i(addr_i), .wstrb_i(wstrb_i), .wdata_i(wdata_i),
    .addr_ok_o(addr_ok_o), .data_ok_o(data_ok_o), .rdata_o(rdata_o),
    .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o), .rd_rdy_i(rd_rdy_i),
    .ret_valid_i(ret_valid_i), .ret_last_i(ret_last_i), .ret_data_i(ret_data_i),
    .wr_req_o(wr_req_o), .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o), .wr_rdy_i(wr_rdy_i)
  );

  mem_model u_mem (
    .clk(clk), .resetn(resetn),
    .rd_req_i(rd_req_o), .rd_addr_i(rd_addr_o), .rd_rdy_o(rd_rdy_i),
    .ret_valid_o(ret_valid_i), .ret_last_o(ret_last_i), .ret_data_o(ret_data_i),
    .wr_req_i(wr_req_o), .wr_addr_i(wr_addr_o), .wr_data_i(wr_data_o), .wr_rdy_o(wr_rdy_i)
  );

  function automatic mem_bus_pkg::word_t fill_word(input mem_bus_pkg::addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic mem_bus_pkg::word_t ref_word(input mem_bus_pkg::addr_t a);
    mem_bus_pkg::addr_t key;
    key = {a[31:2], 2'b00};
    if (ref_mem.exists(key)) begin
      return ref_mem[key];
    end
    return fill_word(key);
  endfunction

  function automatic mem_bus_pkg::line_t ref_line(input mem_bus_pkg::addr_t a);
    mem_bus_pkg::line_t l;
    mem_bus_pkg::addr_t base;
    base = {a[31:4], 4'h0};
    for (int w = 0; w < mem_bus_pkg::BEATS_PER_LINE; w++) begin
      l[w*32 +: 32] = ref_word(base + 4 * w);
    end
    return l;
  endfunction

  // dirty line of the missing request's set, other than its own line
  function automatic logic find_victim(input mem_bus_pkg::addr_t req,
                                       input mem_bus_pkg::addr_t got,
                                       output mem_bus_pkg::addr_t pick);
    mem_bus_pkg::addr_t own;
    logic               found;
    own   = {req[31:4], 4'h0};
    pick  = own;
    found = 1'b0;
    foreach (dirty_lines[cand]) begin
      if (cand[11:4] == own[11:4] && cand != own && (!found || cand == got)) begin
        pick  = cand;
        found = 1'b1;   // prefer the candidate the cache picked
      end
    end
    return found;
  endfunction

  task automatic apply_store(input mem_bus_pkg::addr_t a, input mem_bus_pkg::wstrb_t s,
                             input mem_bus_pkg::word_t d);
    mem_bus_pkg::word_t w;
    w = ref_word(a);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) w[b*8 +: 8] = d[b*8 +: 8];
    end
    ref_mem[{a[31:2], 2'b00}] = w;
  endtask

  task automatic check_word(input string name, input mem_bus_pkg::word_t got,
                            input mem_bus_pkg::word_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_line(input string name, input mem_bus_pkg::line_t got,
                            input mem_bus_pkg::line_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input mem_bus_pkg::addr_t got,
                            input mem_bus_pkg::addr_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic void add_row(input logic op, input mem_bus_pkg::addr_t addr,
                                  input mem_bus_pkg::wstrb_t wstrb,
                                  input mem_bus_pkg::word_t wdata, input logic hit);
    row_t r;
    r.op    = op;
    r.addr  = addr;
    r.wstrb = wstrb;
    r.wdata = wdata;
    r.hit   = hit;
    table_q.push_back(r);
  endfunction

  task automatic build_table();
    add_row(1'b0, 32'h0001_0124, 4'h0, 32'h0, 1'b0);          // cold load miss
    add_row(1'b0, 32'h0001_0124, 4'h0, 32'h0, 1'b1);
    add_row(1'b0, 32'h0001_0128, 4'h0, 32'h0, 1'b1);          // back to back hits
    add_row(1'b0, 32'h0001_012c, 4'h0, 32'h0, 1'b1);
    add_row(1'b1, 32'h0001_0124, 4'b0101, 32'haabb_ccdd, 1'b1);
    add_row(1'b0, 32'h0001_0124, 4'h0, 32'h0, 1'b1);
    add_row(1'b1, 32'h0002_0128, 4'b1100, 32'h1122_3344, 1'b0); // store miss
    add_row(1'b0, 32'h0002_0128, 4'h0, 32'h0, 1'b1);
    add_row(1'b0, 32'h0007_73ac, 4'h0, 32'h0, 1'b0);          // word 3 on last beat
    add_row(1'b0, 32'h0003_0120, 4'h0, 32'h0, 1'b0);
    add_row(1'b0, 32'h0004_012c, 4'h0, 32'h0, 1'b0);
    add_row(1'b1, 32'h0005_0124, 4'hf, 32'h5555_aaaa, 1'b0);
    // two dirty lines then a third tag force a writeback in set 0x05
    add_row(1'b1, 32'h000a_0050, 4'b0011, 32'hdead_beef, 1'b0);
    add_row(1'b1, 32'h000b_0058, 4'b1000, 32'h0102_0304, 1'b0);
    add_row(1'b0, 32'h000c_005c, 4'h0, 32'h0, 1'b0);
    add_row(1'b0, 32'h0001_0124, 4'h0, 32'h0, 1'b0);
    add_row(1'b0, 32'h0002_0128, 4'h0, 32'h0, 1'b0);
    add_row(1'b0, 32'h0003_0120, 4'h0, 32'h0, 1'b0);
    add_row(1'b0, 32'h0004_012c, 4'h0, 32'h0, 1'b0);
    add_row(1'b0, 32'h0005_0124, 4'h0, 32'h0, 1'b0);
    add_row(1'b0, 32'h000a_0050, 4'h0, 32'h0, 1'b0);
    add_row(1'b0, 32'h000b_0058, 4'h0, 32'h0, 1'b0);
  endtask

  task automatic record_accept(input row_t r);
    pend_addr_q.push_back(r.addr);
    pend_load_q.push_back(!r.op);
    pend_hit_q.push_back(r.hit);
    pend_cyc_q.push_back(cyc);
    if (r.op) begin
      apply_store(r.addr, r.wstrb, r.wdata);
      dirty_lines[{r.addr[31:4], 4'h0}] = 1'b1;
    end
    pend_data_q.push_back(ref_word(r.addr));
  endtask

  // a request behind a load hit must be taken in that hit's lookup cycle
  task automatic issue(input row_t r, input logic hit_under_hit);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    valid_i  = 1'b1;
    op_i     = r.op;
    addr_i   = r.addr;
    wstrb_i  = r.wstrb;
    wdata_i  = r.wdata;
    while (!accepted && !timed_out) begin
      @(negedge clk);
      if (addr_ok_o) begin
        accepted = 1'b1;
      end else if (waited == WAIT_LIMIT) begin
        timeout_cnt++;
        timed_out = 1'b1;
        $display("request to %h was never accepted by the cache", r.addr);
      end else begin
        waited++;
      end
    end
    if (accepted) begin
      record_accept(r);
      if (hit_under_hit && waited != 0) begin
        other_cnt++;
        $display("request to %h was not accepted during the previous load hit", r.addr);
      end
    end
    @(posedge clk);
    #1;
    valid_i = 1'b0;
  endtask

  task automatic retire_request();
    if (pend_addr_q.size() == 0) begin
      other_cnt++;
      $display("data_ok_o pulsed at cycle %0d with no request outstanding", cyc);
    end else begin
      if (pend_load_q[0]) check_word("rdata_o", rdata_o, pend_data_q[0]);
      if (pend_hit_q[0] && cyc != pend_cyc_q[0] + 1) begin
        other_cnt++;
        $display("hit to %h answered %0d cycles after acceptance instead of 1",
                 pend_addr_q[0], cyc - pend_cyc_q[0]);
      end
      void'(pend_addr_q.pop_front());
      void'(pend_data_q.pop_front());
      void'(pend_load_q.pop_front());
      void'(pend_hit_q.pop_front());
      void'(pend_cyc_q.pop_front());
    end
  endtask

  // memory side traffic belongs to the oldest request
  task automatic check_bus_traffic();
    mem_bus_pkg::addr_t front;
    mem_bus_pkg::addr_t victim;
    front = (pend_addr_q.size() > 0) ? pend_addr_q[0] : '0;
    if (rd_req_o) check_addr("rd_addr_o", rd_addr_o, {front[31:4], 4'h0});
    if (wr_req_o) begin
      wb_cnt++;
      if (!find_victim(front, wr_addr_o, victim)) begin
        other_cnt++;
        $display("wr_req_o pulsed at cycle %0d with no dirty line in the set", cyc);
      end else begin
        check_addr("wr_addr_o", wr_addr_o, victim);
        check_line("wr_data_o", wr_data_o, ref_line(victim));
        dirty_lines.delete(victim);
      end
    end
  endtask

  always @(negedge clk) begin
    if (resetn) begin
      check_bus_traffic();
      if (data_ok_o) retire_request();
    end
  end

  task automatic drain();
    int waited;
    waited = 0;
    while (pend_addr_q.size() > 0 && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        timeout_cnt++;
        timed_out = 1'b1;
        $display("%0d requests never got data_ok_o", pend_addr_q.size());
      end
    end
  endtask

  initial begin
    resetn  = 1'b0;
    valid_i = 1'b0;
    op_i    = 1'b0;
    addr_i  = '0;
    wstrb_i = '0;
    wdata_i = '0;
    build_table();
    repeat (4) @(posedge clk);
    #1;
    resetn = 1'b1;
    @(negedge clk);
    check_flag("addr_ok_o", addr_ok_o, 1'b0);
    check_flag("data_ok_o", data_ok_o, 1'b0);
    check_flag("rd_req_o", rd_req_o, 1'b0);
    check_flag("wr_req_o", wr_req_o, 1'b0);
    @(posedge clk);
    #1;
    foreach (table_q[i]) begin
      if (!timed_out) begin
        issue(table_q[i], i > 0 && !table_q[i-1].op && table_q[i-1].hit);
      end
    end
    drain();
    if (wb_cnt == 0 && !timed_out) begin
      other_cnt++;
      $display("no dirty line was ever written back");
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d other",
             mismatch_cnt, timeout_cnt, other_cnt);
    if (mismatch_cnt + timeout_cnt + other_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
